/* common/addr_map_pkg.sv */
//////////////////////////////////////////////////
// Address map package
// Bus and table sizes plus the rule word that is
// read either as a range or as a NAPOT region
//////////////////////////////////////////////////

`default_nettype none

package addr_map_pkg;

  // Width of a request address on the bus
  localparam int unsigned ADDR_WIDTH = 16;

  // Number of rule slots in the table
  localparam int unsigned NUM_RULES = 8;

  // Number of target ports behind the decoder
  localparam int unsigned NUM_PORTS = 4;

  // A slot number must reach every one of the NUM_RULES slots
  localparam int unsigned RULE_IDX_WIDTH = 3;

  // A port index must reach every one of the NUM_PORTS targets
  localparam int unsigned PORT_IDX_WIDTH = 2;

  // Range view of a rule word
  // The start address lies inside the region and the end address lies just past it
  // An end address of zero stands for the top of the address space
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] start_addr;
    logic [ADDR_WIDTH-1:0] end_addr;
  } rule_range_t;

  // NAPOT view of a rule word
  // Only the bits where the mask is one take part in the compare
  // A mask with its low n bits clear describes a 2**n byte region at the base
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] base_addr;
    logic [ADDR_WIDTH-1:0] mask;
  } rule_napot_t;

  // One stored word, two readings
  // The per slot napot bit in the table says which member is meant
  // Start and base share the upper half, end and mask share the lower half
  typedef union packed {
    rule_range_t range_view;
    rule_napot_t napot_view;
  } rule_u;

endpackage

`default_nettype wire

/* addr_map/rule_table.sv */
//////////////////////////////////////////////////
// Rule table
// Holds the address rules written through the
// configuration port and shows them all at once
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rule_table (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  // Configuration write port, one slot per strobe
  input  logic                                              cfg_we_i,
  input  logic [addr_map_pkg::RULE_IDX_WIDTH-1:0]           cfg_slot_i,
  input  logic                                              cfg_valid_i,
  input  logic                                              cfg_napot_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0]           cfg_port_i,
  input  addr_map_pkg::rule_u                               cfg_rule_i,
  // Whole table, one entry per slot
  output logic [addr_map_pkg::NUM_RULES-1:0]                rule_valid_o,
  output logic [addr_map_pkg::NUM_RULES-1:0]                rule_napot_o,
  output logic [addr_map_pkg::NUM_RULES-1:0]
               [addr_map_pkg::PORT_IDX_WIDTH-1:0]           rule_port_o,
  output addr_map_pkg::rule_u [addr_map_pkg::NUM_RULES-1:0] rule_word_o
);

  import addr_map_pkg::*;

  // Per slot storage
  // Only the valid bits are control state, the rest is payload
  logic  [NUM_RULES-1:0]                     valid_q;
  logic  [NUM_RULES-1:0]                     napot_q;
  logic  [NUM_RULES-1:0][PORT_IDX_WIDTH-1:0] port_q;
  rule_u [NUM_RULES-1:0]                     word_q;

  // Valid bits
  // Reset empties the table so that no address can match a stale rule
  // A write may also clear a slot by sending cfg_valid_i low
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (cfg_we_i) begin
      valid_q[cfg_slot_i] <= cfg_valid_i;
    end
  end

  // Rule contents
  // The kind bit, the target and the word are taken as given
  // Nothing checks for overlaps or an end below the start
  always_ff @(posedge clk_i) begin
    if (cfg_we_i) begin
      napot_q[cfg_slot_i] <= cfg_napot_i;
      port_q[cfg_slot_i]  <= cfg_port_i;
      word_q[cfg_slot_i]  <= cfg_rule_i;
    end
  end

  // The table is read straight from the flops
  // A request in the same cycle as a write therefore sees the old entry,
  // and the new one takes effect on the next cycle
  assign rule_valid_o = valid_q;
  assign rule_napot_o = napot_q;
  assign rule_port_o  = port_q;
  assign rule_word_o  = word_q;

endmodule

`default_nettype wire

/* addr_map/rule_match.sv */
//////////////////////////////////////////////////
// Rule match, decode stage
// Tests one address against every slot of the
// table and returns one match bit per slot
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rule_match (
  // Address of the request being decoded
  input  logic [addr_map_pkg::ADDR_WIDTH-1:0]               req_addr_i,
  // Rule table contents
  input  logic [addr_map_pkg::NUM_RULES-1:0]                rule_valid_i,
  input  logic [addr_map_pkg::NUM_RULES-1:0]                rule_napot_i,
  input  addr_map_pkg::rule_u [addr_map_pkg::NUM_RULES-1:0] rule_word_i,
  // One bit per slot, set where the slot covers the address
  output logic [addr_map_pkg::NUM_RULES-1:0]                match_o
);

  import addr_map_pkg::*;

  // Every slot gets its own comparator, all of them work in parallel
  for (genvar i = 0; i < NUM_RULES; i++) begin : g_slot

    // The two readings of the same stored word
    rule_range_t rng;
    rule_napot_t npt;

    // Result of each reading, only one of them is used per slot
    logic range_hit;
    logic napot_hit;
    logic above_start;
    logic below_end;

    assign rng = rule_word_i[i].range_view;
    assign npt = rule_word_i[i].napot_view;

    // Range rule
    // The start is inclusive and the end is exclusive
    // A zero end means the region runs up to the top of the address space
    assign above_start = req_addr_i >= rng.start_addr;
    assign below_end   = (req_addr_i < rng.end_addr) || (rng.end_addr == '0);
    assign range_hit   = above_start && below_end;

    // NAPOT rule
    // Any bit that differs from the base under a set mask bit breaks the match
    assign napot_hit = ((req_addr_i ^ npt.base_addr) & npt.mask) == '0;

    // The kind bit picks the reading, and an empty slot never matches
    assign match_o[i] = rule_valid_i[i] && (rule_napot_i[i] ? napot_hit : range_hit);

  end

endmodule

`default_nettype wire

/* addr_map/addr_decode.sv */
//////////////////////////////////////////////////
// Address decode, execute stage
// Resolves the match vector by priority and
// falls back to the default port if enabled
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module addr_decode (
  // One bit per slot from the match stage
  input  logic [addr_map_pkg::NUM_RULES-1:0]          match_i,
  // Target port of every slot
  input  logic [addr_map_pkg::NUM_RULES-1:0]
               [addr_map_pkg::PORT_IDX_WIDTH-1:0]     rule_port_i,
  // Default mapping for addresses that no rule covers
  input  logic                                        default_en_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0]     default_port_i,
  // Decision for the router
  output logic                                        hit_o,
  output logic [addr_map_pkg::PORT_IDX_WIDTH-1:0]     port_o,
  output logic                                        dec_err_o
);

  import addr_map_pkg::*;

  // Port of the winning rule and whether any rule matched at all
  logic                      any_match;
  logic [PORT_IDX_WIDTH-1:0] rule_port;

  // Priority select
  // The loop walks upwards, so a later match overwrites an earlier one
  // and the highest-numbered matching slot wins
  always_comb begin
    any_match = 1'b0;
    rule_port = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (match_i[i]) begin
        any_match = 1'b1;
        rule_port = rule_port_i[i];
      end
    end
  end

  // Final decision
  // A default port turns a miss into a hit, so the error only appears
  // when no rule matches and the default is switched off
  always_comb begin
    hit_o     = 1'b0;
    port_o    = '0;
    dec_err_o = 1'b0;
    if (any_match) begin
      hit_o  = 1'b1;
      port_o = rule_port;
    end else if (default_en_i) begin
      hit_o  = 1'b1;
      port_o = default_port_i;
    end else begin
      // Port stays at zero here, the router ignores it on an error
      dec_err_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/req_router.sv */
//////////////////////////////////////////////////
// Request router, result stage
// Registers each request with its decision and
// fires one port strobe or an error pulse
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module req_router (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Request from the bus, one cycle strobe
  input  logic                                    req_i,
  input  logic [addr_map_pkg::ADDR_WIDTH-1:0]     req_addr_i,
  // Decision of the decode stages for this request
  input  logic                                    hit_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0] port_i,
  input  logic                                    dec_err_i,
  // Routed request, one cycle after req_i
  output logic [addr_map_pkg::NUM_PORTS-1:0]      port_req_o,
  output logic [addr_map_pkg::ADDR_WIDTH-1:0]     port_addr_o,
  // Decode error pulse with the address that missed
  output logic                                    dec_err_o,
  output logic [addr_map_pkg::ADDR_WIDTH-1:0]     err_addr_o
);

  import addr_map_pkg::*;

  // Captured request
  // req_q is the only control bit, the rest only matters while it is set
  logic                      req_q;
  logic                      hit_q;
  logic                      err_q;
  logic [PORT_IDX_WIDTH-1:0] port_q;
  logic [ADDR_WIDTH-1:0]     addr_q;

  // Strobe into the stage
  // A new request may arrive every cycle, so this register is simply
  // overwritten while the previous result is on the outputs
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  // Decision and address ride along with the strobe
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      hit_q  <= hit_i;
      err_q  <= dec_err_i;
      port_q <= port_i;
      addr_q <= req_addr_i;
    end
  end

  // Qualified results of the captured request
  logic route_fire;
  logic err_fire;

  assign route_fire = req_q && hit_q;
  assign err_fire   = req_q && err_q;

  // One-hot strobe
  // Each port compares its own number with the captured index
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign port_req_o[p] = route_fire && (port_q == PORT_IDX_WIDTH'(p));
  end

  // Addresses read as zero when nothing was routed that way
  assign port_addr_o = route_fire ? addr_q : '0;
  assign dec_err_o   = err_fire;
  assign err_addr_o  = err_fire ? addr_q : '0;

endmodule

`default_nettype wire

/* hdl/addr_map_top.sv */
//////////////////////////////////////////////////
// Address map top level
// Rule table, match, decode and router joined
// into one request decoder
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module addr_map_top (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Configuration write into the rule table
  input  logic                                    cfg_we_i,
  input  logic [addr_map_pkg::RULE_IDX_WIDTH-1:0] cfg_slot_i,
  input  logic                                    cfg_valid_i,
  input  logic                                    cfg_napot_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0] cfg_port_i,
  input  addr_map_pkg::rule_u                     cfg_rule_i,
  // Default mapping for unmatched addresses
  input  logic                                    default_en_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0] default_port_i,
  // Incoming request
  input  logic                                    req_i,
  input  logic [addr_map_pkg::ADDR_WIDTH-1:0]     req_addr_i,
  // Routed request or decode error
  output logic [addr_map_pkg::NUM_PORTS-1:0]      port_req_o,
  output logic [addr_map_pkg::ADDR_WIDTH-1:0]     port_addr_o,
  output logic                                    dec_err_o,
  output logic [addr_map_pkg::ADDR_WIDTH-1:0]     err_addr_o
);

  import addr_map_pkg::*;

  // Table contents shared by the match and decode stages
  logic  [NUM_RULES-1:0]                     rule_valid;
  logic  [NUM_RULES-1:0]                     rule_napot;
  logic  [NUM_RULES-1:0][PORT_IDX_WIDTH-1:0] rule_port;
  rule_u [NUM_RULES-1:0]                     rule_word;

  // Combinational decode path into the router
  logic                      dec_hit;
  logic [NUM_RULES-1:0]      match;
  logic [PORT_IDX_WIDTH-1:0] dec_port;
  logic                      dec_err;

  rule_table table_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_slot_i   (cfg_slot_i),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_napot_i  (cfg_napot_i),
    .cfg_port_i   (cfg_port_i),
    .cfg_rule_i   (cfg_rule_i),
    .rule_valid_o (rule_valid),
    .rule_napot_o (rule_napot),
    .rule_port_o  (rule_port),
    .rule_word_o  (rule_word)
  );

  rule_match match_i (
    .req_addr_i   (req_addr_i),
    .rule_valid_i (rule_valid),
    .rule_napot_i (rule_napot),
    .rule_word_i  (rule_word),
    .match_o      (match)
  );

  addr_decode decode_i (
    .match_i        (match),
    .rule_port_i    (rule_port),
    .default_en_i   (default_en_i),
    .default_port_i (default_port_i),
    .hit_o          (dec_hit),
    .port_o         (dec_port),
    .dec_err_o      (dec_err)
  );

  req_router router_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_addr_i  (req_addr_i),
    .hit_i       (dec_hit),
    .port_i      (dec_port),
    .dec_err_i   (dec_err),
    .port_req_o  (port_req_o),
    .port_addr_o (port_addr_o),
    .dec_err_o   (dec_err_o),
    .err_addr_o  (err_addr_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
//////////////////////////////////////////////////
// Testbench clock, 4 ns period
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o = 1'b0
);

  // Half of the 4 ns period
  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
//////////////////////////////////////////////////
// Testbench checker
// Keeps its own rule table and compares every
// routed request with the DUT outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    cfg_we_i,
  input  logic [addr_map_pkg::RULE_IDX_WIDTH-1:0] cfg_slot_i,
  input  logic                                    cfg_valid_i,
  input  logic                                    cfg_napot_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0] cfg_port_i,
  input  logic [31:0]                             cfg_rule_i,
  input  logic                                    default_en_i,
  input  logic [addr_map_pkg::PORT_IDX_WIDTH-1:0] default_port_i,
  input  logic                                    req_i,
  input  logic [addr_map_pkg::ADDR_WIDTH-1:0]     req_addr_i,
  // DUT outputs
  input  logic [addr_map_pkg::NUM_PORTS-1:0]      port_req_i,
  input  logic [addr_map_pkg::ADDR_WIDTH-1:0]     port_addr_i,
  input  logic                                    dec_err_i,
  input  logic [addr_map_pkg::ADDR_WIDTH-1:0]     err_addr_i,
  output int                                      check_count_o,
  output int                                      value_err_o,
  output int                                      strobe_err_o
);

  import addr_map_pkg::*;

  // Reference table
  // The upper half of a word is start or base and the lower half is end or mask
  logic [NUM_RULES-1:0]      m_valid;
  logic [NUM_RULES-1:0]      m_napot;
  logic [PORT_IDX_WIDTH-1:0] m_port [NUM_RULES];
  logic [31:0]               m_word [NUM_RULES];

  // Expected result of the request sampled on the last rising edge
  logic                      exp_req = 1'b0;
  logic                      exp_err;
  logic [PORT_IDX_WIDTH-1:0] exp_port;
  logic [ADDR_WIDTH-1:0]     exp_addr;

  int n_check = 0;
  int n_value = 0;
  int n_strobe = 0;

  assign check_count_o = n_check;
  assign value_err_o   = n_value;
  assign strobe_err_o  = n_strobe;

  // True when one rule covers the address in the form its kind bit selects
  function automatic logic covers(input logic napot, input logic [31:0] word,
                                  input logic [ADDR_WIDTH-1:0] addr);
    logic [ADDR_WIDTH-1:0] lo;
    logic [ADDR_WIDTH-1:0] hi;
    lo = word[31:16];
    hi = word[15:0];
    if (napot) begin
      return (addr & hi) == (lo & hi);
    end
    return (addr >= lo) && ((hi == '0) || (addr < hi));
  endfunction

  // Inputs are stable on the rising edge because the stimulus moves on the falling one
  // The request is decoded first, then the write lands, as in the DUT
  always @(posedge clk_i) begin : sample
    logic                      found;
    logic [PORT_IDX_WIDTH-1:0] port;
    found = 1'b0;
    port  = '0;
    if (rst_i) begin
      m_valid = '0;
      exp_req = 1'b0;
    end else begin
      for (int i = 0; i < NUM_RULES; i++) begin
        if (m_valid[i] && covers(m_napot[i], m_word[i], req_addr_i)) begin
          found = 1'b1;
          port  = m_port[i];
        end
      end
      exp_req  = req_i;
      exp_addr = req_addr_i;
      exp_err  = !found && !default_en_i;
      exp_port = found ? port : default_port_i;
      if (cfg_we_i) begin
        m_valid[cfg_slot_i] = cfg_valid_i;
        m_napot[cfg_slot_i] = cfg_napot_i;
        m_port[cfg_slot_i]  = cfg_port_i;
        m_word[cfg_slot_i]  = cfg_rule_i;
      end
    end
  end

  // DUT outputs come from flops, so mid-cycle they hold the last result
  always @(negedge clk_i) begin : compare
    logic [NUM_PORTS-1:0] exp_strobe;
    exp_strobe = '0;
    if (exp_req && !exp_err) begin
      exp_strobe[exp_port] = 1'b1;
    end
    if (exp_req) begin
      n_check = n_check + 1;
    end
    if (port_req_i !== exp_strobe) begin
      if (port_req_i === '0 || exp_strobe == '0) begin
        n_strobe = n_strobe + 1;
        $display("%0t: port strobe missing or extra, saw %b where %b was due",
                 $time, port_req_i, exp_strobe);
      end else begin
        n_value = n_value + 1;
        $display("Fail %0t: port_req_o is %b, expected %b for address %h",
                 $time, port_req_i, exp_strobe, exp_addr);
      end
    end
    if (dec_err_i !== (exp_req && exp_err)) begin
      n_strobe = n_strobe + 1;
      $display("%0t: decode error pulse missing or extra, saw %b for address %h",
               $time, dec_err_i, exp_addr);
    end
    if (exp_req && !exp_err && port_addr_i !== exp_addr) begin
      n_value = n_value + 1;
      $display("Fail %0t: port_addr_o is %h, expected %h", $time, port_addr_i, exp_addr);
    end
    if (exp_req && exp_err && err_addr_i !== exp_addr) begin
      n_value = n_value + 1;
      $display("Fail %0t: err_addr_o is %h, expected %h", $time, err_addr_i, exp_addr);
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
//////////////////////////////////////////////////
// Testbench top for the address map decoder
// Random rule tables and requests from an LCG
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import addr_map_pkg::*;

  // Cycle budget of every phase, the watchdog adds them up
  localparam int RESET_CYCLES   = 8;
  localparam int EMPTY_CYCLES   = 40;
  localparam int RANGE_CYCLES   = 200;
  localparam int MIXED_CYCLES   = 200;
  localparam int DEFAULT_CYCLES = 150;
  localparam int B2B_CYCLES     = 300;
  localparam int FILL_CYCLES    = 3 * (NUM_RULES + 1);
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + EMPTY_CYCLES + RANGE_CYCLES + MIXED_CYCLES
                                  + DEFAULT_CYCLES + B2B_CYCLES + FILL_CYCLES + 200;

  logic                      clk;
  logic                      rst;
  logic                      cfg_we;
  logic [RULE_IDX_WIDTH-1:0] cfg_slot;
  logic                      cfg_valid;
  logic                      cfg_napot;
  logic [PORT_IDX_WIDTH-1:0] cfg_port;
  logic [31:0]               cfg_rule;
  logic                      default_en;
  logic [PORT_IDX_WIDTH-1:0] default_port;
  logic                      req;
  logic [ADDR_WIDTH-1:0]     req_addr;
  logic [NUM_PORTS-1:0]      port_req;
  logic [ADDR_WIDTH-1:0]     port_addr;
  logic                      dec_err;
  logic [ADDR_WIDTH-1:0]     err_addr;
  int                        check_count;
  int                        value_errs;
  int                        strobe_errs;
  logic [31:0]               rng_state;

  tb_clock clock_i (.clk_o(clk));

  addr_map_top dut_i (
    .clk_i(clk), .rst_i(rst), .cfg_we_i(cfg_we), .cfg_slot_i(cfg_slot),
    .cfg_valid_i(cfg_valid), .cfg_napot_i(cfg_napot), .cfg_port_i(cfg_port),
    .cfg_rule_i(cfg_rule), .default_en_i(default_en), .default_port_i(default_port),
    .req_i(req), .req_addr_i(req_addr), .port_req_o(port_req), .port_addr_o(port_addr),
    .dec_err_o(dec_err), .err_addr_o(err_addr)
  );

  tb_checker checker_i (
    .clk_i(clk), .rst_i(rst), .cfg_we_i(cfg_we), .cfg_slot_i(cfg_slot),
    .cfg_valid_i(cfg_valid), .cfg_napot_i(cfg_napot), .cfg_port_i(cfg_port),
    .cfg_rule_i(cfg_rule), .default_en_i(default_en), .default_port_i(default_port),
    .req_i(req), .req_addr_i(req_addr), .port_req_i(port_req), .port_addr_i(port_addr),
    .dec_err_i(dec_err), .err_addr_i(err_addr), .check_count_o(check_count),
    .value_err_o(value_errs), .strobe_err_o(strobe_errs)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper halves of two steps, the low bits of an LCG repeat too quickly
  task automatic draw(output logic [31:0] v);
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = lcg_step(rng_state);
    s2 = lcg_step(s1);
    rng_state = s2;
    v = {s1[31:16], s2[31:16]};
  endtask

  function automatic logic chance(input logic [7:0] b, input int pct);
    return (int'(b) % 100) < pct;
  endfunction

  // A NAPOT region spans 2**4 to 2**13 addresses, a range rule ends past its start
  // or at zero, which reaches the top of the address space
  task automatic make_rule(input logic napot, output logic [31:0] w);
    logic [31:0]           r;
    logic [ADDR_WIDTH-1:0] hi;
    draw(r);
    if (napot) begin
      hi = 16'hFFFF << (4 + int'(r[3:0]) % 10);
    end else if (r[5:4] == 2'b00) begin
      hi = '0;
    end else begin
      hi = r[31:16] + {1'b0, r[14:0]} + 16'd1;
    end
    w = {r[31:16], hi};
  endtask

  // Writes every slot once with no requests alongside
  task automatic fill_table(input int napot_pct, input int valid_pct);
    logic [31:0] r;
    logic [31:0] w;
    logic        napot;
    for (int s = 0; s < NUM_RULES; s++) begin
      draw(r);
      napot = chance(r[7:0], napot_pct);
      make_rule(napot, w);
      @(negedge clk);
      req       = 1'b0;
      cfg_we    = 1'b1;
      cfg_slot  = s[2:0];
      cfg_valid = chance(r[15:8], valid_pct);
      cfg_napot = napot;
      cfg_port  = r[17:16];
      cfg_rule  = w;
    end
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // Random requests, optionally with random slot writes in the same cycles
  task automatic run_cycles(input int n, input int req_pct, input int cfg_pct,
                            input int napot_pct);
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] w;
    logic        napot;
    repeat (n) begin
      draw(r);
      draw(c);
      napot = chance(c[23:16], napot_pct);
      make_rule(napot, w);
      @(negedge clk);
      req       = chance(r[7:0], req_pct);
      req_addr  = r[31:16];
      cfg_we    = chance(c[7:0], cfg_pct);
      cfg_slot  = c[10:8];
      cfg_valid = c[15:11] != 5'd0;
      cfg_napot = napot;
      cfg_port  = c[25:24];
      cfg_rule  = w;
    end
    @(negedge clk);
    req    = 1'b0;
    cfg_we = 1'b0;
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the stimulus did not finish", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    rng_state    = 32'h9ea6188d;
    rst          = 1'b1;
    cfg_we       = 1'b0;
    cfg_slot     = '0;
    cfg_valid    = 1'b0;
    cfg_napot    = 1'b0;
    cfg_port     = '0;
    cfg_rule     = '0;
    default_en   = 1'b0;
    default_port = '0;
    req          = 1'b0;
    req_addr     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    // Empty table and no default, so every request must miss
    run_cycles(EMPTY_CYCLES, 75, 0, 0);
    fill_table(0, 100);
    run_cycles(RANGE_CYCLES, 75, 0, 0);
    // Both kinds in one table with a few empty slots
    fill_table(50, 85);
    run_cycles(MIXED_CYCLES, 75, 0, 50);
    // A sparse table leaves room for the default port
    fill_table(50, 40);
    default_en = 1'b1;
    for (int k = 0; k < DEFAULT_CYCLES / 25; k++) begin
      default_port = k[1:0];
      run_cycles(25, 75, 0, 50);
    end
    // A request on every cycle with writes mixed in
    for (int k = 0; k < B2B_CYCLES / 50; k++) begin
      default_en = k[0];
      run_cycles(50, 100, 35, 50);
    end
    repeat (3) @(negedge clk);
    $display("Checks %0d, value errors %0d, strobe errors %0d",
             check_count, value_errs, strobe_errs);
    if (value_errs + strobe_errs == 0 && check_count > 0) begin
      $display("TB PASSED");
    end else begin
      if (check_count == 0) begin
        $display("No request reached the checker");
      end
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
common/addr_map_pkg.sv
addr_map/rule_table.sv
addr_map/rule_match.sv
addr_map/addr_decode.sv
hdl/req_router.sv
hdl/addr_map_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* Makefile */
# Verilator build and run of the address map testbench

SIM  := obj_dir/Vtb_top
SRCS := $(shell cat files.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

# Rebuilt only when a source or the file list changes
$(SIM): files.f $(SRCS)
	verilator --binary --top-module tb_top -f files.f -Mdir obj_dir -o Vtb_top

clean:
	rm -rf obj_dir sim.log
